// ==== rtl/core_pkg.sv ====
package core_pkg;

   localparam int DATA_W        = 32;
   localparam int REG_N         = 8;
   localparam int REG_ADDR_W    = 3;
   localparam int ROB_DEPTH     = 8;
   localparam int TAG_W         = 3;
   localparam int STATION_DEPTH = 2;
   localparam int STATION_IDX_W = $clog2(STATION_DEPTH);
   localparam int N_UNITS       = 2;

   localparam int OPCODE_W      = 6;
   localparam int REG_FIELD_W   = 5;
   localparam int IMM_W         = 16;

   localparam logic [OPCODE_W-1:0] OP_ADD  = 6'd1;
   localparam logic [OPCODE_W-1:0] OP_SUB  = 6'd2;
   localparam logic [OPCODE_W-1:0] OP_AND  = 6'd3;
   localparam logic [OPCODE_W-1:0] OP_OR   = 6'd4;
   localparam logic [OPCODE_W-1:0] OP_XOR  = 6'd5;
   localparam logic [OPCODE_W-1:0] OP_ADDI = 6'd6;
   localparam logic [OPCODE_W-1:0] OP_SETI = 6'd7;

   // Only the low REG_ADDR_W bits of a register field index the file
   typedef struct packed {
      logic [OPCODE_W-1:0]    opcode;
      logic [REG_FIELD_W-1:0] rd;
      logic [REG_FIELD_W-1:0] rs1;
      logic [REG_FIELD_W-1:0] rs2;
      logic [10:0]            unused;
   } inst_r_t;

   typedef struct packed {
      logic [OPCODE_W-1:0]    opcode;
      logic [REG_FIELD_W-1:0] rd;
      logic [REG_FIELD_W-1:0] rs1;
      logic [IMM_W-1:0]       imm;
   } inst_i_t;

   typedef union packed {
      inst_r_t r;
      inst_i_t i;
   } inst_u;

   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      logic [DATA_W-1:0] value;
      logic              ready;
   } operand_t;

   typedef struct packed {
      logic [OPCODE_W-1:0] opcode;
      logic [TAG_W-1:0]    tag;
      operand_t            a;
      operand_t            b;
   } issue_t;

   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      logic [DATA_W-1:0] value;
   } cdb_t;

   typedef struct packed {
      logic [REG_ADDR_W-1:0] rd;
      logic [DATA_W-1:0]     value;
   } commit_t;

endpackage

// ==== rtl/dispatch.sv ====
`timescale 1ns/1ps

module dispatch (
   input  core_pkg::inst_u                         i_inst,
   input  logic                                    i_inst_valid,
   output logic                                    o_inst_ready,
   output logic [1:0][core_pkg::REG_ADDR_W-1:0]    o_rd_addr,
   input  core_pkg::operand_t [1:0]                i_rd_op,
   output logic [1:0][core_pkg::TAG_W-1:0]         o_rob_tag_q,
   input  core_pkg::operand_t [1:0]                i_rob_op,
   input  logic                                    i_cdb_valid,
   input  core_pkg::cdb_t                          i_cdb,
   output logic                                    o_alloc,
   output logic [core_pkg::REG_ADDR_W-1:0]         o_alloc_rd,
   input  logic [core_pkg::TAG_W-1:0]              i_alloc_tag,
   input  logic                                    i_rob_ready,
   output logic [core_pkg::N_UNITS-1:0]            o_issue_valid,
   output core_pkg::issue_t                        o_issue,
   input  logic [core_pkg::N_UNITS-1:0]            i_station_ready
);

   logic [core_pkg::OPCODE_W-1:0] opcode;
   logic                          is_alu;
   logic                          is_imm;
   logic                          can_issue;
   logic [core_pkg::N_UNITS-1:0]  station_sel;
   core_pkg::operand_t [1:0]      src_op;

   assign opcode       = i_inst.r.opcode;
   assign o_rd_addr[0] = i_inst.r.rs1[core_pkg::REG_ADDR_W-1:0];
   assign o_rd_addr[1] = i_inst.r.rs2[core_pkg::REG_ADDR_W-1:0];
   assign o_alloc_rd   = i_inst.r.rd[core_pkg::REG_ADDR_W-1:0];

   always_comb begin
      is_alu = 1'b0;
      is_imm = 1'b0;
      case (opcode)
         core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND,
         core_pkg::OP_OR, core_pkg::OP_XOR: begin
            is_alu = 1'b1;
         end
         core_pkg::OP_ADDI, core_pkg::OP_SETI: begin
            is_alu = 1'b1;
            is_imm = 1'b1;
         end
         default: begin
            is_alu = 1'b0;
         end
      endcase
   end

   // Register file first, then a finished ROB entry, then the bus this cycle
   always_comb begin
      for (int k = 0; k < 2; k++) begin
         o_rob_tag_q[k] = i_rd_op[k].tag;
         if (i_rd_op[k].ready) begin
            src_op[k] = i_rd_op[k];
         end else if (i_rob_op[k].ready) begin
            src_op[k] = i_rob_op[k];
         end else if (i_cdb_valid && (i_cdb.tag == i_rd_op[k].tag)) begin
            src_op[k].tag   = i_cdb.tag;
            src_op[k].value = i_cdb.value;
            src_op[k].ready = 1'b1;
         end else begin
            src_op[k] = i_rd_op[k];
         end
      end
   end

   // Lowest set bit of the ready vector
   assign station_sel = i_station_ready & (~i_station_ready + 1'b1);

   assign can_issue     = i_inst_valid && is_alu && i_rob_ready && (|i_station_ready);
   assign o_inst_ready  = !is_alu || (i_rob_ready && (|i_station_ready));
   assign o_alloc       = can_issue;
   assign o_issue_valid = can_issue ? station_sel : '0;

   always_comb begin
      o_issue.opcode = opcode;
      o_issue.tag    = i_alloc_tag;
      o_issue.a      = src_op[0];
      o_issue.b      = src_op[1];
      if (opcode == core_pkg::OP_SETI) begin
         o_issue.a.tag   = '0;
         o_issue.a.value = '0;
         o_issue.a.ready = 1'b1;
      end
      if (is_imm) begin
         o_issue.b.tag   = '0;
         o_issue.b.value = (core_pkg::DATA_W)'(i_inst.i.imm);
         o_issue.b.ready = 1'b1;
      end
   end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
   input  logic                                 clk,
   input  logic                                 nrst,
   input  logic [1:0][core_pkg::REG_ADDR_W-1:0] i_rd_addr,
   output core_pkg::operand_t [1:0]             o_rd_op,
   input  logic                                 i_rename,
   input  logic [core_pkg::REG_ADDR_W-1:0]      i_rename_rd,
   input  logic [core_pkg::TAG_W-1:0]           i_rename_tag,
   input  logic                                 i_commit_we,
   input  core_pkg::commit_t                    i_commit,
   input  logic [core_pkg::TAG_W-1:0]           i_commit_tag
);

   logic [core_pkg::DATA_W-1:0] value [core_pkg::REG_N];
   logic [core_pkg::TAG_W-1:0]  tag   [core_pkg::REG_N];
   logic [core_pkg::REG_N-1:0]  busy;

   // Busy register hands out its producer tag instead of a value
   always_comb begin
      for (int k = 0; k < 2; k++) begin
         o_rd_op[k].tag   = tag[i_rd_addr[k]];
         o_rd_op[k].value = value[i_rd_addr[k]];
         o_rd_op[k].ready = !busy[i_rd_addr[k]];
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         for (int r = 0; r < core_pkg::REG_N; r++) begin
            value[r] <= '0;
            tag[r]   <= '0;
         end
         busy <= '0;
      end else begin
         if (i_commit_we) begin
            value[i_commit.rd] <= i_commit.value;
            // Only the newest producer frees the register
            if (tag[i_commit.rd] == i_commit_tag) begin
               busy[i_commit.rd] <= 1'b0;
            end
         end
         // Later write, so a rename overrides the clear
         if (i_rename) begin
            busy[i_rename_rd] <= 1'b1;
            tag[i_rename_rd]  <= i_rename_tag;
         end
      end
   end

endmodule

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
   input  logic                              clk,
   input  logic                              nrst,
   input  logic                              i_alloc,
   input  logic [core_pkg::REG_ADDR_W-1:0]   i_alloc_rd,
   output logic [core_pkg::TAG_W-1:0]        o_alloc_tag,
   output logic                              o_ready,
   input  logic                              i_cdb_valid,
   input  core_pkg::cdb_t                    i_cdb,
   input  logic [1:0][core_pkg::TAG_W-1:0]   i_tag_q,
   output core_pkg::operand_t [1:0]          o_op,
   output logic                              o_commit_valid,
   output core_pkg::commit_t                 o_commit,
   output logic [core_pkg::TAG_W-1:0]        o_commit_tag,
   input  logic                              i_commit_ready
);

   logic [core_pkg::REG_ADDR_W-1:0] ent_rd    [core_pkg::ROB_DEPTH];
   logic [core_pkg::DATA_W-1:0]     ent_value [core_pkg::ROB_DEPTH];
   logic [core_pkg::ROB_DEPTH-1:0]  ent_done;
   logic [core_pkg::TAG_W-1:0]      head;
   logic [core_pkg::TAG_W-1:0]      tail;
   logic [core_pkg::TAG_W:0]        count;
   logic                            do_commit;

   assign o_ready        = count != (core_pkg::TAG_W + 1)'(core_pkg::ROB_DEPTH);
   assign o_alloc_tag    = tail;
   assign o_commit_valid = (count != '0) && ent_done[head];
   assign o_commit_tag   = head;
   assign do_commit      = o_commit_valid && i_commit_ready;

   always_comb begin
      o_commit.rd    = ent_rd[head];
      o_commit.value = ent_value[head];
   end

   // Operand lookup by tag
   always_comb begin
      for (int k = 0; k < 2; k++) begin
         o_op[k].tag   = i_tag_q[k];
         o_op[k].value = ent_value[i_tag_q[k]];
         o_op[k].ready = ent_done[i_tag_q[k]];
      end
   end

   always_ff @(posedge clk) begin
      if (i_alloc) begin
         ent_rd[tail] <= i_alloc_rd;
      end
      if (i_cdb_valid) begin
         ent_value[i_cdb.tag] <= i_cdb.value;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         head     <= '0;
         tail     <= '0;
         count    <= '0;
         ent_done <= '0;
      end else begin
         if (i_alloc) begin
            ent_done[tail] <= 1'b0;
            tail           <= tail + 1'b1;
         end
         if (i_cdb_valid) begin
            ent_done[i_cdb.tag] <= 1'b1;
         end
         if (do_commit) begin
            head <= head + 1'b1;
         end
         case ({i_alloc, do_commit})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== rtl/alu_station.sv ====
`timescale 1ns/1ps

module alu_station (
   input  logic             clk,
   input  logic             nrst,
   input  logic             i_issue_valid,
   input  core_pkg::issue_t i_issue,
   output logic             o_ready,
   input  logic             i_cdb_valid,
   input  core_pkg::cdb_t   i_cdb,
   output logic             o_valid,
   output core_pkg::cdb_t   o_result,
   input  logic             i_grant
);

   core_pkg::issue_t                     ent [core_pkg::STATION_DEPTH];
   logic [core_pkg::STATION_DEPTH-1:0]   ent_valid;
   logic [core_pkg::STATION_IDX_W-1:0]   free_idx;
   logic [core_pkg::STATION_IDX_W-1:0]   exec_idx;
   logic                                 has_free;
   logic                                 has_exec;
   logic                                 do_exec;
   logic [core_pkg::DATA_W-1:0]          alu_out;
   logic                                 res_valid;
   core_pkg::cdb_t                       res;

   // Walk downward so the lowest index wins
   always_comb begin
      has_free = 1'b0;
      free_idx = '0;
      has_exec = 1'b0;
      exec_idx = '0;
      for (int i = core_pkg::STATION_DEPTH - 1; i >= 0; i--) begin
         if (!ent_valid[i]) begin
            has_free = 1'b1;
            free_idx = i[core_pkg::STATION_IDX_W-1:0];
         end
         if (ent_valid[i] && ent[i].a.ready && ent[i].b.ready) begin
            has_exec = 1'b1;
            exec_idx = i[core_pkg::STATION_IDX_W-1:0];
         end
      end
   end

   // Result register must be empty or leaving this cycle
   assign do_exec  = has_exec && (!res_valid || i_grant);
   assign o_ready  = has_free;
   assign o_valid  = res_valid;
   assign o_result = res;

   always_comb begin
      case (ent[exec_idx].opcode)
         core_pkg::OP_ADD, core_pkg::OP_ADDI:
            alu_out = ent[exec_idx].a.value + ent[exec_idx].b.value;
         core_pkg::OP_SUB:
            alu_out = ent[exec_idx].a.value - ent[exec_idx].b.value;
         core_pkg::OP_AND:
            alu_out = ent[exec_idx].a.value & ent[exec_idx].b.value;
         core_pkg::OP_OR:
            alu_out = ent[exec_idx].a.value | ent[exec_idx].b.value;
         core_pkg::OP_XOR:
            alu_out = ent[exec_idx].a.value ^ ent[exec_idx].b.value;
         core_pkg::OP_SETI:
            alu_out = ent[exec_idx].b.value;
         default:
            alu_out = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < core_pkg::STATION_DEPTH; i++) begin
         if (ent_valid[i] && i_cdb_valid) begin
            if (!ent[i].a.ready && (ent[i].a.tag == i_cdb.tag)) begin
               ent[i].a.value <= i_cdb.value;
               ent[i].a.ready <= 1'b1;
            end
            if (!ent[i].b.ready && (ent[i].b.tag == i_cdb.tag)) begin
               ent[i].b.value <= i_cdb.value;
               ent[i].b.ready <= 1'b1;
            end
         end
      end
      if (i_issue_valid) begin
         ent[free_idx] <= i_issue;
      end
      if (do_exec) begin
         res.tag   <= ent[exec_idx].tag;
         res.value <= alu_out;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         ent_valid <= '0;
         res_valid <= 1'b0;
      end else begin
         if (do_exec) begin
            ent_valid[exec_idx] <= 1'b0;
         end
         if (i_issue_valid) begin
            ent_valid[free_idx] <= 1'b1;
         end
         if (do_exec) begin
            res_valid <= 1'b1;
         end else if (i_grant) begin
            res_valid <= 1'b0;
         end
      end
   end

endmodule

// ==== rtl/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
   input  logic [core_pkg::N_UNITS-1:0]           i_valid,
   input  core_pkg::cdb_t [core_pkg::N_UNITS-1:0] i_result,
   output logic [core_pkg::N_UNITS-1:0]           o_grant,
   output logic                                   o_cdb_valid,
   output core_pkg::cdb_t                         o_cdb
);

   logic [core_pkg::N_UNITS-1:0] grant_v [core_pkg::N_UNITS+1];
   core_pkg::cdb_t               cdb_v   [core_pkg::N_UNITS+1];

   assign grant_v[core_pkg::N_UNITS] = '0;
   assign cdb_v[core_pkg::N_UNITS]   = '0;

   // Priority chain from the top unit down, unit 0 decides last
   for (genvar i = 0; i < core_pkg::N_UNITS; i++) begin : g_walk
      assign grant_v[i] = i_valid[i] ? (core_pkg::N_UNITS)'(1 << i) : grant_v[i+1];
      assign cdb_v[i]   = i_valid[i] ? i_result[i] : cdb_v[i+1];
   end

   assign o_grant     = grant_v[0];
   assign o_cdb       = cdb_v[0];
   assign o_cdb_valid = |i_valid;

endmodule

// ==== rtl/ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core (
   input  logic              clk,
   input  logic              nrst,
   input  logic              i_inst_valid,
   input  core_pkg::inst_u   i_inst,
   output logic              o_inst_ready,
   output logic              o_commit_valid,
   output core_pkg::commit_t o_commit,
   input  logic              i_commit_ready
);

   logic [1:0][core_pkg::REG_ADDR_W-1:0]   rd_addr;
   core_pkg::operand_t [1:0]               rd_op;
   logic [1:0][core_pkg::TAG_W-1:0]        rob_tag_q;
   core_pkg::operand_t [1:0]               rob_op;
   logic                                   alloc;
   logic [core_pkg::REG_ADDR_W-1:0]        alloc_rd;
   logic [core_pkg::TAG_W-1:0]             alloc_tag;
   logic                                   rob_ready;
   logic [core_pkg::N_UNITS-1:0]           issue_valid;
   core_pkg::issue_t                       issue;
   logic [core_pkg::N_UNITS-1:0]           station_ready;
   logic [core_pkg::N_UNITS-1:0]           unit_valid;
   core_pkg::cdb_t [core_pkg::N_UNITS-1:0] unit_result;
   logic [core_pkg::N_UNITS-1:0]           cdb_grant;
   logic                                   cdb_valid;
   core_pkg::cdb_t                         cdb;
   logic [core_pkg::TAG_W-1:0]             commit_tag;
   logic                                   commit_we;

   assign commit_we = o_commit_valid & i_commit_ready;

   dispatch u_dispatch (
      .i_inst          (i_inst),
      .i_inst_valid    (i_inst_valid),
      .o_inst_ready    (o_inst_ready),
      .o_rd_addr       (rd_addr),
      .i_rd_op         (rd_op),
      .o_rob_tag_q     (rob_tag_q),
      .i_rob_op        (rob_op),
      .i_cdb_valid     (cdb_valid),
      .i_cdb           (cdb),
      .o_alloc         (alloc),
      .o_alloc_rd      (alloc_rd),
      .i_alloc_tag     (alloc_tag),
      .i_rob_ready     (rob_ready),
      .o_issue_valid   (issue_valid),
      .o_issue         (issue),
      .i_station_ready (station_ready)
   );

   register_file u_regs (
      .clk          (clk),
      .nrst         (nrst),
      .i_rd_addr    (rd_addr),
      .o_rd_op      (rd_op),
      .i_rename     (alloc),
      .i_rename_rd  (alloc_rd),
      .i_rename_tag (alloc_tag),
      .i_commit_we  (commit_we),
      .i_commit     (o_commit),
      .i_commit_tag (commit_tag)
   );

   reorder_buffer u_rob (
      .clk            (clk),
      .nrst           (nrst),
      .i_alloc        (alloc),
      .i_alloc_rd     (alloc_rd),
      .o_alloc_tag    (alloc_tag),
      .o_ready        (rob_ready),
      .i_cdb_valid    (cdb_valid),
      .i_cdb          (cdb),
      .i_tag_q        (rob_tag_q),
      .o_op           (rob_op),
      .o_commit_valid (o_commit_valid),
      .o_commit       (o_commit),
      .o_commit_tag   (commit_tag),
      .i_commit_ready (i_commit_ready)
   );

   for (genvar u = 0; u < core_pkg::N_UNITS; u++) begin : g_station
      alu_station u_station (
         .clk           (clk),
         .nrst          (nrst),
         .i_issue_valid (issue_valid[u]),
         .i_issue       (issue),
         .o_ready       (station_ready[u]),
         .i_cdb_valid   (cdb_valid),
         .i_cdb         (cdb),
         .o_valid       (unit_valid[u]),
         .o_result      (unit_result[u]),
         .i_grant       (cdb_grant[u])
      );
   end

   cdb_arbiter u_arbiter (
      .i_valid     (unit_valid),
      .i_result    (unit_result),
      .o_grant     (cdb_grant),
      .o_cdb_valid (cdb_valid),
      .o_cdb       (cdb)
   );

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
   output logic clk,
   output logic nrst
);

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Reset is active high, released just after the fifth rising edge
   initial begin
      nrst = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      nrst = 1'b0;
   end

endmodule

// ==== tb/core_chk.sv ====
`timescale 1ns/1ps

module core_chk (
   input logic                         clk,
   input logic                         nrst,
   input logic                         i_inst_valid,
   input core_pkg::inst_u              i_inst,
   input logic                         i_inst_ready,
   input logic                         i_commit_valid,
   input core_pkg::commit_t            i_commit,
   input logic                         i_commit_ready,
   input logic [core_pkg::N_UNITS-1:0] i_unit_valid,
   input logic [core_pkg::N_UNITS-1:0] i_grant
);

   inst_hold: assert property (@(posedge clk) disable iff (nrst)
      (i_inst_valid && !i_inst_ready) |=> (i_inst_valid && $stable(i_inst)))
      else $error("instruction word changed while waiting for ready");

   commit_hold: assert property (@(posedge clk) disable iff (nrst)
      (i_commit_valid && !i_commit_ready) |=> (i_commit_valid && $stable(i_commit)))
      else $error("commit output changed while stalled");

   reset_quiet: assert property (@(posedge clk)
      nrst |=> !i_commit_valid)
      else $error("commit valid high right after reset");

   // At most one grant and only to the lowest unit holding a result
   grant_lowest: assert property (@(posedge clk) disable iff (nrst)
      $onehot0(i_grant) && ((i_grant & ~i_unit_valid) == '0)
      && (((i_grant - 1'b1) & i_unit_valid) == '0))
      else $error("CDB grant missing or not on the lowest unit with a result");

endmodule

bind ooo_core core_chk u_core_chk (
   .clk            (clk),
   .nrst           (nrst),
   .i_inst_valid   (i_inst_valid),
   .i_inst         (i_inst),
   .i_inst_ready   (o_inst_ready),
   .i_commit_valid (o_commit_valid),
   .i_commit       (o_commit),
   .i_commit_ready (i_commit_ready),
   .i_unit_valid   (unit_valid),
   .i_grant        (cdb_grant)
);

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

   localparam int CHAIN_LEN       = 32;
   localparam int INDEP_LEN       = 32;
   localparam int STALL_LEN       = 24;
   localparam int RANDOM_LEN      = 400;
   localparam int STALL_CYCLES    = 60;
   localparam int CYCLES_PER_INST = 20;

   logic              clk;
   logic              nrst;
   logic              i_inst_valid;
   core_pkg::inst_u   i_inst;
   logic              o_inst_ready;
   logic              o_commit_valid;
   core_pkg::commit_t o_commit;
   logic              i_commit_ready;

   logic [31:0]       rng_state;
   logic [31:0]       prog_q [$];
   core_pkg::commit_t expect_q [$];
   logic [31:0]       model_regs [core_pkg::REG_N];
   int                stall_at;
   int                stall_left;
   logic              saw_full;
   int                cycle_count = 0;
   int                timeout_cycles = 0;

   clk_gen u_clk_gen (
      .clk  (clk),
      .nrst (nrst)
   );

   ooo_core DUT (
      .clk            (clk),
      .nrst           (nrst),
      .i_inst_valid   (i_inst_valid),
      .i_inst         (i_inst),
      .o_inst_ready   (o_inst_ready),
      .o_commit_valid (o_commit_valid),
      .o_commit       (o_commit),
      .i_commit_ready (i_commit_ready)
   );

   task automatic stop_on_error();
      $display("Something failed");
      $fatal(1, "run stopped at first error");
   endtask

   function automatic logic [31:0] xorshift_next();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // Upper register field bits and unused bits get noise
   function automatic logic [31:0] rtype_word(input logic [5:0] op, input logic [2:0] rd,
                                              input logic [2:0] rs1, input logic [2:0] rs2);
      logic [31:0] junk;
      junk = xorshift_next();
      return {op, junk[1:0], rd, junk[3:2], rs1, junk[5:4], rs2, junk[16:6]};
   endfunction

   function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [2:0] rd,
                                              input logic [2:0] rs1, input logic [15:0] imm);
      logic [31:0] junk;
      junk = xorshift_next();
      return {op, junk[1:0], rd, junk[3:2], rs1, imm};
   endfunction

   // Opcodes 8 to 63 do nothing
   function automatic logic [31:0] nop_word();
      logic [31:0] r;
      logic [5:0]  op;
      r  = xorshift_next();
      op = 6'(8 + (r % 56));
      return {op, r[31:6]};
   endfunction

   // Registers 0 to 3 only, so dependencies are frequent
   function automatic logic [31:0] random_word();
      logic [31:0] r;
      logic [5:0]  op;
      logic [31:0] word;
      r  = xorshift_next();
      op = 6'(1 + (r[7:4] % 7));
      if (r[3:0] == 4'hf) begin
         word = nop_word();
      end else if (op == core_pkg::OP_ADDI || op == core_pkg::OP_SETI) begin
         word = itype_word(op, {1'b0, r[9:8]}, {1'b0, r[11:10]}, r[31:16]);
      end else begin
         word = rtype_word(op, {1'b0, r[9:8]}, {1'b0, r[11:10]}, {1'b0, r[13:12]});
      end
      return word;
   endfunction

   task automatic build_program();
      logic [31:0] r;
      logic [5:0]  op;
      logic [2:0]  prev_rd;
      logic [2:0]  rd;
      // Reads of unwritten registers, and a dropped word
      prog_q.push_back(nop_word());
      prog_q.push_back(rtype_word(core_pkg::OP_ADD, 3'd1, 3'd5, 3'd6));
      prog_q.push_back(rtype_word(core_pkg::OP_XOR, 3'd2, 3'd7, 3'd4));
      // Each link reads the previous destination
      prev_rd = 3'd3;
      prog_q.push_back(itype_word(core_pkg::OP_SETI, prev_rd, 3'd0, 16'hbeef));
      for (int k = 0; k < CHAIN_LEN; k++) begin
         r  = xorshift_next();
         op = 6'(1 + (r[3:0] % 6));
         rd = r[6:4];
         if (op == core_pkg::OP_ADDI) begin
            prog_q.push_back(itype_word(op, rd, prev_rd, r[31:16]));
         end else begin
            prog_q.push_back(rtype_word(op, rd, prev_rd, r[9:7]));
         end
         prev_rd = rd;
      end
      // Writes r0..r3 from r4..r7, no links inside the group
      for (int k = 0; k < INDEP_LEN; k++) begin
         r  = xorshift_next();
         op = 6'(1 + (r[3:0] % 7));
         rd = 3'(k % 4);
         if (op == core_pkg::OP_ADDI || op == core_pkg::OP_SETI) begin
            prog_q.push_back(itype_word(op, rd, {1'b1, r[5:4]}, r[31:16]));
         end else begin
            prog_q.push_back(rtype_word(op, rd, {1'b1, r[5:4]}, {1'b1, r[7:6]}));
         end
      end
      stall_at = prog_q.size();
      for (int k = 0; k < STALL_LEN + RANDOM_LEN; k++) begin
         prog_q.push_back(random_word());
      end
   endtask

   task automatic model_exec(input logic [31:0] word);
      logic [5:0]        op;
      logic [2:0]        rd;
      logic [31:0]       a;
      logic [31:0]       b;
      logic [31:0]       imm;
      logic [31:0]       result;
      logic              writes;
      core_pkg::commit_t entry;
      op     = word[31:26];
      rd     = word[23:21];
      a      = model_regs[word[18:16]];
      b      = model_regs[word[13:11]];
      imm    = {16'h0000, word[15:0]};
      writes = 1'b1;
      case (op)
         core_pkg::OP_ADD:  result = a + b;
         core_pkg::OP_SUB:  result = a - b;
         core_pkg::OP_AND:  result = a & b;
         core_pkg::OP_OR:   result = a | b;
         core_pkg::OP_XOR:  result = a ^ b;
         core_pkg::OP_ADDI: result = a + imm;
         core_pkg::OP_SETI: result = imm;
         default: begin
            result = '0;
            writes = 1'b0;
         end
      endcase
      if (writes) begin
         model_regs[rd] = result;
         entry.rd       = rd;
         entry.value    = result;
         expect_q.push_back(entry);
      end
   endtask

   task automatic check_commit();
      core_pkg::commit_t exp;
      assert (expect_q.size() != 0) else begin
         $display("commit to r%0d with no result outstanding", o_commit.rd);
         stop_on_error();
      end
      exp = expect_q.pop_front();
      assert (o_commit.rd == exp.rd) else begin
         $display("mismatch o_commit.rd: got %h expected %h", o_commit.rd, exp.rd);
         stop_on_error();
      end
      assert (o_commit.value == exp.value) else begin
         $display("mismatch o_commit.value: got %h expected %h", o_commit.value, exp.value);
         stop_on_error();
      end
   endtask

   task automatic drive_commit_ready();
      if (stall_left > 0) begin
         i_commit_ready = 1'b0;
         stall_left--;
      end else begin
         i_commit_ready = (xorshift_next() % 4) != 0;
      end
   endtask

   // Handshakes are settled at the falling edge and happen at the next rising edge
   always @(negedge clk) begin
      if (!nrst) begin
         if (o_commit_valid && i_commit_ready) begin
            check_commit();
         end
         if (i_inst_valid && o_inst_ready) begin
            model_exec(i_inst);
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      assert (timeout_cycles == 0 || cycle_count < timeout_cycles) else begin
         $display("timeout after %0d cycles without reaching the end of the test", cycle_count);
         stop_on_error();
      end
   end

   initial begin
      int idx;
      int drain;
      i_inst_valid   = 1'b0;
      i_inst         = '0;
      i_commit_ready = 1'b0;
      rng_state      = 32'd48;
      stall_left     = 0;
      saw_full       = 1'b0;
      for (int r = 0; r < core_pkg::REG_N; r++) begin
         model_regs[r] = '0;
      end
      build_program();
      timeout_cycles = prog_q.size() * CYCLES_PER_INST;
      wait (nrst === 1'b0);

      // Nothing may commit before the first word goes in
      repeat (4) begin
         drive_commit_ready();
         @(negedge clk);
         assert (!o_commit_valid) else begin
            $display("commit valid before any instruction was accepted");
            stop_on_error();
         end
         @(posedge clk);
         #1;
      end

      idx = 0;
      while (idx < prog_q.size()) begin
         if (idx == stall_at) begin
            stall_left = STALL_CYCLES;
            stall_at   = -1;
         end
         i_inst_valid = 1'b1;
         i_inst       = prog_q[idx];
         drive_commit_ready();
         @(negedge clk);
         if (stall_left > 0 && !o_inst_ready) begin
            saw_full = 1'b1;
         end
         if (o_inst_ready) begin
            idx++;
         end
         @(posedge clk);
         #1;
      end
      i_inst_valid = 1'b0;
      i_inst       = '0;

      drain = 0;
      while (expect_q.size() != 0 && drain < 400) begin
         drive_commit_ready();
         @(posedge clk);
         #1;
         drain++;
      end
      // Quiet period, any extra commit fails in the monitor
      repeat (20) begin
         drive_commit_ready();
         @(posedge clk);
         #1;
      end

      assert (saw_full) else begin
         $display("commit stall never pushed back on the instruction stream");
         stop_on_error();
      end
      if (expect_q.size() == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         $display("%0d expected commits never appeared", expect_q.size());
         stop_on_error();
      end
   end

endmodule

// ==== all.f ====
rtl/core_pkg.sv
rtl/dispatch.sv
rtl/register_file.sv
rtl/reorder_buffer.sv
rtl/alu_station.sv
rtl/cdb_arbiter.sv
rtl/ooo_core.sv
tb/clk_gen.sv
tb/core_chk.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, simulate, then judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f all.f \
   || { echo "build failed"; exit 1; }
./obj_dir/Vtb_top > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Everything OK" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
